/* common/ising_cfg.svh */
// Ising energy monitor sizes

`ifndef ISING_CFG_SVH
`define ISING_CFG_SVH

// ==========================================================
// Problem size
// ==========================================================

// Spins per configuration, one weight row each
`define ISING_DATASPIN 16

// ==========================================================
// Coefficient widths
// ==========================================================

`define ISING_BITJ 4          // J coupling, sign-magnitude
`define ISING_BITH 4          // h bias, two's complement
`define ISING_SCALING_BIT 4   // Unsigned h scale factor

// ==========================================================
// Energy widths
// ==========================================================

`define ISING_ENERGY_BIT 16      // Signed energy of one spin
`define ISING_ENERGY_ACC_BIT 24  // Signed sum over all spins

`endif

/* common/ising_pkg.sv */
// Ising energy monitor types

`default_nettype none

`include "ising_cfg.svh"

package ising_pkg;

    // One bit per spin, bit k is spin k
    typedef logic [`ISING_DATASPIN-1:0] spin_vec_t;

    // J row of one spin, element j in bits [j*BITJ +: BITJ]
    typedef logic [`ISING_DATASPIN*`ISING_BITJ-1:0] weight_row_t;

    // h bias of one spin
    typedef logic [`ISING_BITH-1:0] hbias_t;

    // Bias scale, treated as unsigned
    typedef logic [`ISING_SCALING_BIT-1:0] hscale_t;

    // Row counter
    typedef logic [$clog2(`ISING_DATASPIN)-1:0] spin_idx_t;

    // Energy of a single spin
    typedef logic signed [`ISING_ENERGY_BIT-1:0] partial_energy_t;

    // Energy of the whole configuration
    typedef logic signed [`ISING_ENERGY_ACC_BIT-1:0] total_energy_t;

endpackage

`default_nettype wire

/* energy/adder_tree.sv */
// Signed adder tree

`timescale 1ns/10ps
`default_nettype none

module adder_tree #(
    parameter int N     = 4,   // Number of operands
    parameter int DATAW = 8,   // Operand width
    parameter int SUMW  = 16   // Result width
)(
    input  logic signed [N-1:0][DATAW-1:0] data_i, // Operands, each signed
    output logic signed [SUMW-1:0]         sum_o   // Sum of all operands
);

    // Leaves padded up to a power of two
    localparam int LEAVES = 1 << $clog2(N);

    // Heap numbering
    // node 1 is the root, node i has children 2i and 2i+1,
    // leaves sit at LEAVES .. 2*LEAVES-1
    logic signed [SUMW-1:0] node [1:2*LEAVES-1];

    genvar i;

    // ==========================================================
    // Leaves
    // ==========================================================
    generate
        for (i = 0; i < LEAVES; i++) begin : g_leaf
            if (i < N) begin : g_operand
                // Signed source, so widening extends the sign
                assign node[LEAVES+i] = $signed(data_i[i]);
            end else begin : g_pad
                assign node[LEAVES+i] = '0; // Padding, adds nothing
            end
        end
    endgenerate

    // ==========================================================
    // Inner nodes, one adder each
    // ==========================================================
    generate
        for (i = 1; i < LEAVES; i++) begin : g_node
            assign node[i] = node[2*i] + node[2*i+1];
        end
    endgenerate

    assign sum_o = node[1]; // Root holds the full sum

endmodule

`default_nettype wire

/* energy/partial_energy_calc.sv */
// Single spin energy

`timescale 1ns/10ps
`default_nettype none

`include "ising_cfg.svh"

module partial_energy_calc #(
    parameter int BITJ             = `ISING_BITJ,
    parameter int BITH             = `ISING_BITH,
    parameter int DATASPIN         = `ISING_DATASPIN,
    parameter int SCALING_BIT      = `ISING_SCALING_BIT,
    parameter int ENERGY_TOTAL_BIT = `ISING_ENERGY_BIT
)(
    input  ising_pkg::spin_vec_t       spin_i,      // Spin configuration
    input  ising_pkg::spin_vec_t       spin_mask_i, // One-hot, spin under evaluation
    input  ising_pkg::weight_row_t     weight_i,    // J row, sign-magnitude
    input  ising_pkg::hbias_t          hbias_i,     // h of the masked spin
    input  ising_pkg::hscale_t         hscaling_i,  // Unsigned h scale
    output ising_pkg::partial_energy_t energy_o     // Energy of the masked spin
);

    // Scaled bias needs BITH+SCALING_BIT, negated J needs BITJ+1
    localparam int MULTBIT = BITH + SCALING_BIT;
    localparam int TERMW   = (MULTBIT > BITJ + 1) ? MULTBIT : BITJ + 1;

    logic signed [DATASPIN-1:0][BITJ-1:0]  weight_2c;    // Two's complement J
    logic signed [DATASPIN-1:0][TERMW-1:0] term;         // One term per position
    logic signed [TERMW-1:0]               bias_term;    // h times scale
    logic                                  masked_bit;   // Spin under evaluation
    logic signed [ENERGY_TOTAL_BIT-1:0]    energy_local; // Sum before final sign

    // ==========================================================
    // Sign-magnitude to two's complement
    // ==========================================================
    always_comb begin
        logic [BITJ-1:0] w_sm;
        for (int i = 0; i < DATASPIN; i++) begin
            w_sm = weight_i[i*BITJ +: BITJ];
            // Magnitude with a zero on top, then negate for sign set
            // Negative zero ends up as plain zero
            if (w_sm[BITJ-1]) begin
                weight_2c[i] = -$signed({1'b0, w_sm[BITJ-2:0]});
            end else begin
                weight_2c[i] = $signed({1'b0, w_sm[BITJ-2:0]});
            end
        end
    end

    // Scale is unsigned, zero bit keeps it positive
    assign bias_term = $signed(hbias_i) * $signed({1'b0, hscaling_i});

    // Value of the masked spin, mask is one-hot
    assign masked_bit = |(spin_i & spin_mask_i);

    // ==========================================================
    // Term selection
    // ==========================================================
    always_comb begin
        logic signed [TERMW-1:0] w_ext;
        for (int i = 0; i < DATASPIN; i++) begin
            w_ext = $signed(weight_2c[i]); // Sign-extend to term width
            if (spin_mask_i[i]) begin
                term[i] = bias_term;       // Diagonal replaced by bias
            end else if (spin_i[i]) begin
                term[i] = w_ext;           // Spin up
            end else begin
                term[i] = -w_ext;          // Spin down
            end
        end
    end

    // ==========================================================
    // Reduction
    // ==========================================================
    adder_tree #(
        .N     (DATASPIN),
        .DATAW (TERMW),
        .SUMW  (ENERGY_TOTAL_BIT)
    ) u_adder_tree (
        .data_i (term),
        .sum_o  (energy_local)
    );

    // Whole row flips with the masked spin
    assign energy_o = masked_bit ? energy_local : -energy_local;

endmodule

`default_nettype wire

/* rtl/energy_ctrl.sv */
// Energy monitor job and row control

`timescale 1ns/10ps
`default_nettype none

`include "ising_cfg.svh"

module energy_ctrl (
    input  wire                        clk_i,
    input  wire                        reset_i,        // Sync, active high

    // Job port
    input  wire                        job_valid_i,
    output logic                       job_ready_o,
    input  ising_pkg::spin_vec_t       job_spin_i,
    input  ising_pkg::hscale_t         job_hscale_i,

    // Row port
    input  wire                        row_valid_i,
    output logic                       row_ready_o,
    input  ising_pkg::weight_row_t     row_weight_i,
    input  ising_pkg::hbias_t          row_hbias_i,

    // Calculator side
    output ising_pkg::spin_vec_t       calc_spin_o,
    output ising_pkg::spin_vec_t       calc_mask_o,
    output ising_pkg::weight_row_t     calc_weight_o,
    output ising_pkg::hbias_t          calc_hbias_o,
    output ising_pkg::hscale_t         calc_hscale_o,
    input  ising_pkg::partial_energy_t calc_energy_i,

    // Accumulator side
    input  wire                        result_busy_i,  // Total pending or being built
    output ising_pkg::partial_energy_t pe_o,
    output logic                       pe_valid_o,
    output logic                       pe_last_o
);

    typedef enum logic {
        IDLE,  // Waiting for a job
        ROWS   // Taking weight rows
    } state_t;

    state_t                     state_q;
    ising_pkg::spin_idx_t       row_cnt_q;  // Index of the row presented
    ising_pkg::spin_vec_t       spin_q;     // Spins of the current job
    ising_pkg::hscale_t         hscale_q;   // Scale of the current job
    ising_pkg::partial_energy_t pe_q;
    logic                       pe_valid_q;
    logic                       pe_last_q;
    logic                       run_q;      // Set once out of reset
    logic                       job_hs;
    logic                       row_hs;
    logic                       last_row;

    // ==========================================================
    // Handshakes
    // ==========================================================
    assign job_ready_o = run_q && (state_q == IDLE) && !result_busy_i;
    assign row_ready_o = (state_q == ROWS);
    assign job_hs      = job_valid_i && job_ready_o;
    assign row_hs      = row_valid_i && row_ready_o;
    assign last_row    = (row_cnt_q == ising_pkg::spin_idx_t'(`ISING_DATASPIN - 1));

    // Calculator inputs
    assign calc_spin_o   = spin_q;
    assign calc_mask_o   = ising_pkg::spin_vec_t'(1) << row_cnt_q; // One-hot on row k
    assign calc_hscale_o = hscale_q;
    assign calc_weight_o = row_weight_i;  // Row goes straight to the calculator
    assign calc_hbias_o  = row_hbias_i;

    // ==========================================================
    // FSM and row counter
    // ==========================================================
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q   <= IDLE;
            row_cnt_q <= '0;
            run_q     <= 1'b0;
        end else begin
            run_q <= 1'b1;
            case (state_q)
                IDLE: begin
                    if (job_hs) begin
                        state_q   <= ROWS;
                        row_cnt_q <= '0;      // First row is spin 0
                    end
                end
                ROWS: begin
                    if (row_hs) begin
                        row_cnt_q <= row_cnt_q + 1'b1;
                        if (last_row) begin
                            state_q <= IDLE;  // All rows taken
                        end
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    // Job payload, loaded on accept
    always_ff @(posedge clk_i) begin
        if (job_hs) begin
            spin_q   <= job_spin_i;
            hscale_q <= job_hscale_i;
        end
    end

    // ==========================================================
    // Partial energy register
    // ==========================================================
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            pe_valid_q <= 1'b0;
            pe_last_q  <= 1'b0;
        end else begin
            pe_valid_q <= row_hs;              // One cycle per row
            pe_last_q  <= row_hs && last_row;
        end
    end

    always_ff @(posedge clk_i) begin
        if (row_hs) begin
            pe_q <= calc_energy_i;
        end
    end

    assign pe_o       = pe_q;
    assign pe_valid_o = pe_valid_q;
    assign pe_last_o  = pe_last_q;

endmodule

`default_nettype wire

/* rtl/energy_accumulator.sv */
// Total energy accumulator

`timescale 1ns/10ps
`default_nettype none

module energy_accumulator (
    input  wire                        clk_i,
    input  wire                        reset_i,        // Sync, active high

    // Partial energies from the controller
    input  ising_pkg::partial_energy_t pe_i,
    input  wire                        pe_valid_i,
    input  wire                        pe_last_i,      // Final row of the job

    // Result port
    output logic                       energy_valid_o,
    input  wire                        energy_ready_i,
    output ising_pkg::total_energy_t   energy_o,

    output logic                       result_busy_o   // Back to the controller
);

    ising_pkg::total_energy_t sum_q;     // Running sum
    ising_pkg::total_energy_t energy_q;  // Held result
    ising_pkg::total_energy_t pe_ext;    // Widened partial
    ising_pkg::total_energy_t sum_next;
    logic                     acc_q;     // Job in progress
    logic                     valid_q;

    // Signed source, so this sign-extends
    assign pe_ext = pe_i;

    // First partial of a job starts a new sum
    assign sum_next = acc_q ? sum_q + pe_ext : pe_ext;

    // ==========================================================
    // Running sum
    // ==========================================================
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            sum_q <= '0;
            acc_q <= 1'b0;
        end else if (pe_valid_i) begin
            sum_q <= sum_next;
            acc_q <= !pe_last_i;  // Job ends with the last partial
        end
    end

    // ==========================================================
    // Result register and handshake
    // ==========================================================
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            valid_q <= 1'b0;
        end else if (pe_valid_i && pe_last_i) begin
            valid_q <= 1'b1;
        end else if (energy_ready_i) begin
            valid_q <= 1'b0;   // Taken, or nothing was offered
        end
    end

    always_ff @(posedge clk_i) begin
        if (pe_valid_i && pe_last_i) begin
            energy_q <= sum_next;  // Held until taken
        end
    end

    assign energy_valid_o = valid_q;
    assign energy_o       = energy_q;

    // Also busy while a partial is still on the way in
    assign result_busy_o = acc_q || valid_q || pe_valid_i;

endmodule

`default_nettype wire

/* rtl/energy_monitor.sv */
// Ising energy monitor top

`timescale 1ns/10ps
`default_nettype none

`include "ising_cfg.svh"

module energy_monitor (
    input  wire                      clk_i,
    input  wire                      reset_i,         // Sync, active high

    // Job port
    input  wire                      job_valid_i,
    output logic                     job_ready_o,
    input  ising_pkg::spin_vec_t     job_spin_i,      // Spin configuration
    input  ising_pkg::hscale_t       job_hscale_i,    // h scale for this job

    // Row port, one row per spin in order
    input  wire                      row_valid_i,
    output logic                     row_ready_o,
    input  ising_pkg::weight_row_t   row_weight_i,
    input  ising_pkg::hbias_t        row_hbias_i,

    // Result port
    output logic                     energy_valid_o,
    input  wire                      energy_ready_i,
    output ising_pkg::total_energy_t energy_o
);

    ising_pkg::spin_vec_t       calc_spin;
    ising_pkg::spin_vec_t       calc_mask;
    ising_pkg::weight_row_t     calc_weight;
    ising_pkg::hbias_t          calc_hbias;
    ising_pkg::hscale_t         calc_hscale;
    ising_pkg::partial_energy_t calc_energy;
    ising_pkg::partial_energy_t pe;
    logic                       pe_valid;
    logic                       pe_last;
    logic                       result_busy;

    // ==========================================================
    // Control
    // ==========================================================
    energy_ctrl u_ctrl (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .job_valid_i    (job_valid_i),
        .job_ready_o    (job_ready_o),
        .job_spin_i     (job_spin_i),
        .job_hscale_i   (job_hscale_i),
        .row_valid_i    (row_valid_i),
        .row_ready_o    (row_ready_o),
        .row_weight_i   (row_weight_i),
        .row_hbias_i    (row_hbias_i),
        .calc_spin_o    (calc_spin),
        .calc_mask_o    (calc_mask),
        .calc_weight_o  (calc_weight),
        .calc_hbias_o   (calc_hbias),
        .calc_hscale_o  (calc_hscale),
        .calc_energy_i  (calc_energy),
        .result_busy_i  (result_busy),
        .pe_o           (pe),
        .pe_valid_o     (pe_valid),
        .pe_last_o      (pe_last)
    );

    // Combinational, settles within the row cycle
    partial_energy_calc #(
        .BITJ             (`ISING_BITJ),
        .BITH             (`ISING_BITH),
        .DATASPIN         (`ISING_DATASPIN),
        .SCALING_BIT      (`ISING_SCALING_BIT),
        .ENERGY_TOTAL_BIT (`ISING_ENERGY_BIT)
    ) u_calc (
        .spin_i      (calc_spin),
        .spin_mask_i (calc_mask),
        .weight_i    (calc_weight),
        .hbias_i     (calc_hbias),
        .hscaling_i  (calc_hscale),
        .energy_o    (calc_energy)
    );

    energy_accumulator u_acc (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .pe_i           (pe),
        .pe_valid_i     (pe_valid),
        .pe_last_i      (pe_last),
        .energy_valid_o (energy_valid_o),
        .energy_ready_i (energy_ready_i),
        .energy_o       (energy_o),
        .result_busy_o  (result_busy)
    );

endmodule

`default_nettype wire

/* dv/tb_energy_monitor.sv */
// Energy monitor testbench

`timescale 1ns/10ps
`default_nettype none

`include "ising_cfg.svh"

module tb_energy_monitor;

    localparam int N_SPIN      = `ISING_DATASPIN;
    localparam int BITJ        = `ISING_BITJ;
    localparam int BITH        = `ISING_BITH;
    localparam int LATENCY     = 2;  // Handshake edge and result edge both counted
    localparam int MAX_JOBS    = 20;
    localparam int ROW_CYCLES  = 4;  // Worst row with its gap
    localparam int WATCHDOG_NS = (MAX_JOBS * N_SPIN * ROW_CYCLES + 500) * 10;

    logic                     clk_i = 1'b0;
    logic                     reset_i;
    logic                     job_valid_i;
    logic                     job_ready_o;
    ising_pkg::spin_vec_t     job_spin_i;
    ising_pkg::hscale_t       job_hscale_i;
    logic                     row_valid_i;
    logic                     row_ready_o;
    ising_pkg::weight_row_t   row_weight_i;
    ising_pkg::hbias_t        row_hbias_i;
    logic                     energy_valid_o;
    logic                     energy_ready_i;
    ising_pkg::total_energy_t energy_o;

    // Stimulus of the current job
    ising_pkg::spin_vec_t     job_spin;
    ising_pkg::hscale_t       job_scale;
    ising_pkg::weight_row_t   row_w [N_SPIN];
    ising_pkg::hbias_t        row_h [N_SPIN];
    ising_pkg::total_energy_t saved_total [4];  // Back-to-back expectations for the gap replay

    logic [31:0] rng_q = 32'h341797ee;  // Data stream
    logic [31:0] gap_q = 32'h341797ee;  // Separate gap stream so data replays
    logic [31:0] saved_rng;
    int          errors = 0;
    int          checks = 0;

    always #5 clk_i = ~clk_i;  // 10 ns period

    energy_monitor u_dut (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .job_valid_i    (job_valid_i),
        .job_ready_o    (job_ready_o),
        .job_spin_i     (job_spin_i),
        .job_hscale_i   (job_hscale_i),
        .row_valid_i    (row_valid_i),
        .row_ready_o    (row_ready_o),
        .row_weight_i   (row_weight_i),
        .row_hbias_i    (row_hbias_i),
        .energy_valid_o (energy_valid_o),
        .energy_ready_i (energy_ready_i),
        .energy_o       (energy_o)
    );

    // ==========================================================
    // Random numbers and reference model
    // ==========================================================
    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [15:0] next_rand();
        rng_q = lcg_step(rng_q);
        return rng_q[31:16];  // Upper bits since low ones cycle fast
    endfunction

    // Sign-magnitude J where both zero codes give 0
    function automatic int coupling(input logic [BITJ-1:0] code);
        int mag;
        mag = int'(code[BITJ-2:0]);
        return code[BITJ-1] ? -mag : mag;
    endfunction

    function automatic int bias_value(input ising_pkg::hbias_t h);
        int hv;
        hv = int'(h);
        if (h[BITH-1]) hv -= (1 << BITH);  // Two's complement
        return hv;
    endfunction

    function automatic ising_pkg::total_energy_t model_energy();
        int total;
        int row_sum;
        total = 0;
        for (int k = 0; k < N_SPIN; k++) begin
            row_sum = 0;
            for (int j = 0; j < N_SPIN; j++) begin
                if (j == k) row_sum += bias_value(row_h[k]) * int'(job_scale); // Diagonal
                else if (job_spin[j]) row_sum += coupling(row_w[k][j*BITJ +: BITJ]);
                else row_sum -= coupling(row_w[k][j*BITJ +: BITJ]);
            end
            total += job_spin[k] ? row_sum : -row_sum;  // Flip with spin k
        end
        return ising_pkg::total_energy_t'(total);
    endfunction

    task automatic gen_job();
        job_spin  = next_rand();
        job_scale = ising_pkg::hscale_t'(next_rand());
        for (int k = 0; k < N_SPIN; k++) begin
            row_w[k] = {next_rand(), next_rand(), next_rand(), next_rand()};
            row_h[k] = ising_pkg::hbias_t'(next_rand());
        end
    endtask

    // ==========================================================
    // Compare tasks
    // ==========================================================
    task automatic check_energy(input string name, input ising_pkg::total_energy_t exp,
                                input ising_pkg::total_energy_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Fail %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic check_latency(input string name, input int exp, input int act);
        checks++;
        if (act != exp) begin
            errors++;
            $display("Fail %s latency: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Fail %s: expected %0b, actual %0b", name, exp, act);
        end
    endtask

    // ==========================================================
    // Drivers
    // ==========================================================
    task automatic send_job();
        job_valid_i  = 1'b1;
        job_spin_i   = job_spin;
        job_hscale_i = job_scale;
        @(negedge clk_i);
        while (!job_ready_o) @(negedge clk_i);
        @(posedge clk_i);  // Job accepted on this edge
        #1;
        job_valid_i = 1'b0;
    endtask

    task automatic send_rows(input bit gaps);
        int gap;
        for (int k = 0; k < N_SPIN; k++) begin
            gap = 0;
            if (gaps) begin
                gap_q = lcg_step(gap_q);
                gap   = int'(gap_q[31:30]);  // 0 to 3 idle cycles
            end
            repeat (gap) begin
                @(posedge clk_i);
                #1;
            end
            row_valid_i  = 1'b1;
            row_weight_i = row_w[k];
            row_hbias_i  = row_h[k];
            @(negedge clk_i);
            while (!row_ready_o) @(negedge clk_i);
            @(posedge clk_i);  // Row k taken
            #1;
            row_valid_i = 1'b0;
        end
    endtask

    // Ends on the negedge where the result is seen
    task automatic wait_result(output ising_pkg::total_energy_t got, output int lat);
        lat = 1;  // Last row handshake edge
        @(negedge clk_i);
        while (!energy_valid_o && lat < 50) begin
            @(posedge clk_i);
            lat++;
            @(negedge clk_i);
        end
        if (!energy_valid_o) begin
            errors++;
            $display("No result appeared after the last row was accepted");
        end
        got = energy_o;
    endtask

    task automatic run_job(input string name, input bit gaps,
                           output ising_pkg::total_energy_t got);
        ising_pkg::total_energy_t exp;
        int                       lat;
        exp = model_energy();
        send_job();
        send_rows(gaps);
        wait_result(got, lat);
        check_energy(name, exp, got);
        check_latency(name, LATENCY, lat);
        @(posedge clk_i);  // Taken since energy_ready_i is high
        #1;
    endtask

    // ==========================================================
    // Tests
    // ==========================================================
    task automatic zero_test();
        ising_pkg::total_energy_t got;
        gen_job();
        job_scale = '0;
        for (int k = 0; k < N_SPIN; k++) begin
            row_w[k] = '0;
            row_h[k] = '0;
        end
        run_job("zero_random_spins", 1'b0, got);
        check_energy("zero_random_spins_direct", '0, got);
        job_spin = '1;
        run_job("zero_all_up", 1'b0, got);
        check_energy("zero_all_up_direct", '0, got);
    endtask

    task automatic random_test();
        ising_pkg::total_energy_t got;
        ising_pkg::total_energy_t up_exp;
        saved_rng = rng_q;
        for (int i = 0; i < 4; i++) begin
            gen_job();
            saved_total[i] = model_energy();
            run_job("random_back_to_back", 1'b0, got);
        end
        gen_job();
        job_scale = '0;  // Bias off so a full flip keeps the total
        job_spin  = '1;
        up_exp    = model_energy();
        run_job("flip_all_up", 1'b0, got);
        job_spin = '0;
        run_job("flip_all_down", 1'b0, got);
        check_energy("flip_symmetry", up_exp, got);
    endtask

    task automatic negzero_bias_test();
        ising_pkg::total_energy_t got;
        int                       exp;
        gen_job();
        exp = 0;
        for (int k = 0; k < N_SPIN; k++) begin
            row_w[k] = {N_SPIN{1'b1, {(BITJ-1){1'b0}}}};  // Negative zero everywhere
            exp += (job_spin[k] ? 1 : -1) * bias_value(row_h[k]) * int'(job_scale);
        end
        run_job("negative_zero", 1'b0, got);
        check_energy("negative_zero_direct", ising_pkg::total_energy_t'(exp), got);
        for (int k = 0; k < N_SPIN; k++) begin
            row_w[k][k*BITJ +: BITJ] = {1'b0, {(BITJ-1){1'b1}}};  // Diagonal J replaced by h
        end
        run_job("diagonal_ignored", 1'b0, got);
        check_energy("diagonal_ignored_direct", ising_pkg::total_energy_t'(exp), got);
    endtask

    task automatic gap_test();
        ising_pkg::total_energy_t got;
        rng_q = saved_rng;  // Same jobs as the back-to-back run
        for (int i = 0; i < 4; i++) begin
            gen_job();
            run_job("random_gaps", 1'b1, got);
            check_energy("gaps_match_back_to_back", saved_total[i], got);
        end
    endtask

    task automatic backpressure_test();
        ising_pkg::total_energy_t exp;
        ising_pkg::total_energy_t exp_next;
        ising_pkg::total_energy_t got;
        int                       lat;
        energy_ready_i = 1'b0;
        gen_job();
        exp = model_energy();
        send_job();
        send_rows(1'b0);
        wait_result(got, lat);
        check_energy("backpressure", exp, got);
        check_latency("backpressure", LATENCY, lat);
        gen_job();  // Next job offered while the result waits
        exp_next = model_energy();
        @(posedge clk_i);
        #1;
        job_valid_i  = 1'b1;
        job_spin_i   = job_spin;
        job_hscale_i = job_scale;
        repeat (6) begin
            @(negedge clk_i);
            check_energy("backpressure_hold", exp, energy_o);
            check_flag("backpressure_valid_hold", 1'b1, energy_valid_o);
            check_flag("backpressure_job_refused", 1'b0, job_ready_o);
            check_flag("backpressure_rows_refused", 1'b0, row_ready_o);
        end
        @(posedge clk_i);
        #1;
        energy_ready_i = 1'b1;
        send_job();
        send_rows(1'b0);
        wait_result(got, lat);
        check_energy("after_backpressure", exp_next, got);
        check_latency("after_backpressure", LATENCY, lat);
        @(posedge clk_i);
        #1;
    endtask

    // ==========================================================
    // Main sequence and watchdog
    // ==========================================================
    initial begin
        reset_i        = 1'b1;
        job_valid_i    = 1'b0;
        job_spin_i     = '0;
        job_hscale_i   = '0;
        row_valid_i    = 1'b0;
        row_weight_i   = '0;
        row_hbias_i    = '0;
        energy_ready_i = 1'b1;
        repeat (2) @(posedge clk_i);
        @(negedge clk_i);
        check_flag("reset_job_ready", 1'b0, job_ready_o);
        check_flag("reset_row_ready", 1'b0, row_ready_o);
        check_flag("reset_result_valid", 1'b0, energy_valid_o);
        repeat (2) @(posedge clk_i);  // 4 reset cycles in all
        #1;
        reset_i = 1'b0;
        zero_test();
        random_test();
        negzero_bias_test();
        gap_test();
        backpressure_test();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired, the DUT stopped handshaking");
        $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* energy_monitor.f */
+incdir+common
common/ising_pkg.sv
energy/adder_tree.sv
energy/partial_energy_calc.sv
rtl/energy_ctrl.sv
rtl/energy_accumulator.sv
rtl/energy_monitor.sv
dv/tb_energy_monitor.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the energy monitor testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
    -f energy_monitor.f \
    --top-module tb_energy_monitor \
    -Mdir obj_dir

output=$(./obj_dir/Vtb_energy_monitor)
echo "$output"

if grep -qx "TEST OK" <<< "$output"; then
    exit 0
else
    exit 1
fi
